//--- source/exuPkg.sv
/*
  Shared widths, op encodings and CSR addresses for the execute unit.
  branchT uses a sparse 3-bit encoding (jal=1, jalr=2, beq..bge=4..7).
*/
package exuPkg;

    localparam int xlen = 64;

    typedef logic [xlen-1:0] xlenT;
    typedef logic [4:0]      regIdxT;
    typedef logic [11:0]     csrAddrT;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt,
        aluSltu, aluXor, aluSrl, aluSra,
        aluOr, aluAnd, aluAddw, aluSubw,
        aluSllw, aluSrlw, aluSraw, aluLui
    } aluOpT;

    typedef enum logic [1:0] {
        mulNone, mulMul, mulMulw
    } mulOpT;

    // taken decision for blt/bge comes from the slt result bit
    typedef enum logic [2:0] {
        brNone = 3'd0,
        brJal  = 3'd1,
        brJalr = 3'd2,
        brBeq  = 3'd4,
        brBne  = 3'd5,
        brBlt  = 3'd6,
        brBge  = 3'd7
    } branchT;

    typedef enum logic [1:0] {
        csrNone, csrRw, csrRs, csrRc
    } csrOpT;

    typedef enum logic [1:0] {
        srcBReg, srcBImm, srcBFour
    } srcBT;

    typedef enum logic [1:0] {
        stIdle, stExec, stMul, stDone
    } ctrlStateT;

    localparam csrAddrT csrMepc   = 12'h341;
    localparam csrAddrT csrMcause = 12'h342;
    localparam csrAddrT csrMtvec  = 12'h305;

    localparam xlenT causeEcallM = 64'd11;

endpackage

//--- source/exuCtrl.sv
/*
  Execute controller. One instruction in flight; inReady only in idle.
  Non-multiply results are latched one cycle after acceptance.
*/
`timescale 1ns/1ps

module exuCtrl (
    input  logic          clk,
    input  logic          arstN,
    input  logic          inValid,
    input  logic          resReady,
    input  exuPkg::mulOpT mulOp,
    input  logic          mulDone,
    output logic          inReady,
    output logic          resValid,
    output logic          latch,
    output logic          mulStart,
    output logic          mulStep,
    output logic          commit
);
    import exuPkg::*;

    ctrlStateT state;
    ctrlStateT stateNext;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stIdle;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            stIdle: begin
                if (inValid) begin
                    stateNext = (mulOp != mulNone) ? stMul : stExec;
                end
            end
            stExec: stateNext = stDone;
            stMul: begin
                if (mulDone) begin
                    stateNext = stDone;
                end
            end
            // hold the result until the consumer takes it
            stDone: begin
                if (resReady) begin
                    stateNext = stIdle;
                end
            end
            default: stateNext = stIdle;
        endcase
    end

    assign inReady  = (state == stIdle);
    assign resValid = (state == stDone);
    assign mulStart = inReady && inValid && (mulOp != mulNone);
    assign mulStep  = (state == stMul) && !mulDone;
    // result register load, on the way into done
    assign latch    = (state == stExec) || ((state == stMul) && mulDone);
    assign commit   = resValid && resReady;

endmodule

//--- source/mulCounter.sv
/*
  Iteration counter for the shift-add multiplier.
  done stays high from the last step until the next start.
*/
`timescale 1ns/1ps

module mulCounter #(
    parameter int mulSteps = 64
) (
    input  logic clk,
    input  logic arstN,
    input  logic start,
    input  logic step,
    output logic done
);
    localparam int cntW = $clog2(mulSteps + 1);

    logic [cntW-1:0] count;
    logic            loaded;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            count  <= '0;
            loaded <= 1'b0;
        end else if (start) begin
            count  <= cntW'(mulSteps);
            loaded <= 1'b1;
        end else if (step && (count != '0)) begin
            count <= count - 1'b1;
        end
    end

    assign done = loaded && (count == '0);

endmodule

//--- source/shiftMul.sv
/*
  Shift-add multiplier, one multiplier bit per step, low 64 bits only.
  Only the low mulSteps bits of b take part; word selects the mulw result.
*/
`timescale 1ns/1ps

module shiftMul #(
    parameter int mulSteps = 64
) (
    input  logic         clk,
    input  logic         arstN,
    input  logic         start,
    input  logic         step,
    input  exuPkg::xlenT a,
    input  exuPkg::xlenT b,
    input  logic         word,
    output exuPkg::xlenT product
);
    import exuPkg::*;

    localparam xlenT bitMask = (mulSteps >= xlen) ? '1 : ((xlenT'(1) << mulSteps) - xlenT'(1));

    xlenT mcand;
    xlenT mplier;
    xlenT acc;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mcand  <= '0;
            mplier <= '0;
            acc    <= '0;
        end else if (start) begin
            mcand  <= a;
            mplier <= b & bitMask;
            acc    <= '0;
        end else if (step) begin
            // add the shifted multiplicand for a set bit
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign product = word ? {{32{acc[31]}}, acc[31:0]} : acc;

endmodule

//--- source/alu.sv
/*
  64-bit ALU, combinational. Word ops sign-extend from bit 31.
  less is bit 0 of the result, valid when the op is slt or sltu.
*/
`timescale 1ns/1ps

module alu (
    input  exuPkg::xlenT  a,
    input  exuPkg::xlenT  b,
    input  exuPkg::aluOpT op,
    output exuPkg::xlenT  result,
    output logic          zero,
    output logic          less
);
    import exuPkg::*;

    logic [31:0] wordRes;

    // 32-bit results for the w variants
    always_comb begin
        case (op)
            aluAddw: wordRes = a[31:0] + b[31:0];
            aluSubw: wordRes = a[31:0] - b[31:0];
            aluSllw: wordRes = a[31:0] << b[4:0];
            aluSrlw: wordRes = a[31:0] >> b[4:0];
            aluSraw: wordRes = $signed(a[31:0]) >>> b[4:0];
            default: wordRes = '0;
        endcase
    end

    always_comb begin
        case (op)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluSll:  result = a << b[5:0];
            aluSlt:  result = {63'd0, $signed(a) < $signed(b)};
            aluSltu: result = {63'd0, a < b};
            aluXor:  result = a ^ b;
            aluSrl:  result = a >> b[5:0];
            aluSra:  result = $signed(a) >>> b[5:0];
            aluOr:   result = a | b;
            aluAnd:  result = a & b;
            aluLui:  result = b;
            aluAddw,
            aluSubw,
            aluSllw,
            aluSrlw,
            aluSraw: result = {{32{wordRes[31]}}, wordRes};
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);
    // branch compare uses slt, so bit 0 is the signed-less flag
    assign less = result[0];

endmodule

//--- source/nextAddr.sv
/*
  Next-pc unit. ecall takes priority over mret. Bit 0 of dnpc is always cleared,
  which also covers the jalr target rule.
*/
`timescale 1ns/1ps

module nextAddr (
    input  exuPkg::branchT branch,
    input  logic           zero,
    input  logic           less,
    input  exuPkg::xlenT   pc,
    input  exuPkg::xlenT   imm,
    input  exuPkg::xlenT   rs1Val,
    input  exuPkg::xlenT   mepc,
    input  exuPkg::xlenT   mtvec,
    input  logic           ecall,
    input  logic           mret,
    output exuPkg::xlenT   dnpc
);
    import exuPkg::*;

    logic useRs1;
    logic taken;
    xlenT sum;

    always_comb begin
        useRs1 = 1'b0;
        case (branch)
            brJal:   taken = 1'b1;
            brJalr: begin
                useRs1 = 1'b1;
                taken  = 1'b1;
            end
            brBeq:   taken = zero;
            brBne:   taken = !zero;
            brBlt:   taken = less;
            brBge:   taken = zero || !less;
            default: taken = 1'b0;
        endcase
    end

    assign sum  = (useRs1 ? rs1Val : pc) + (taken ? imm : xlenT'(4));
    assign dnpc = ecall ? {mtvec[63:1], 1'b0} :
                  mret  ? {mepc[63:1], 1'b0}  :
                          {sum[63:1], 1'b0};

endmodule

//--- source/regFile.sv
/*
  32 x 64 register file, two combinational reads, one write port.
  x0 reads as zero and drops writes.
*/
`timescale 1ns/1ps

module regFile (
    input  logic          clk,
    input  logic          arstN,
    input  exuPkg::regIdxT raAddr,
    input  exuPkg::regIdxT rbAddr,
    input  exuPkg::regIdxT wAddr,
    input  exuPkg::xlenT   wData,
    input  logic           wEn,
    output exuPkg::xlenT   raData,
    output exuPkg::xlenT   rbData
);
    import exuPkg::*;

    xlenT regs [1:31];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wEn && (wAddr != '0)) begin
            regs[wAddr] <= wData;
        end
    end

    assign raData = (raAddr == '0) ? '0 : regs[raAddr];
    assign rbData = (rbAddr == '0) ? '0 : regs[rbAddr];

endmodule

//--- source/csrFile.sv
/*
  mepc, mcause and mtvec only; other addresses read zero and ignore writes.
  All updates, including the ecall trap, happen on commit.
*/
`timescale 1ns/1ps

module csrFile (
    input  logic            clk,
    input  logic            arstN,
    input  exuPkg::csrAddrT addr,
    input  exuPkg::csrOpT   op,
    input  exuPkg::xlenT    wData,
    input  logic            commit,
    input  logic            ecall,
    input  exuPkg::xlenT    pc,
    output exuPkg::xlenT    rData,
    output exuPkg::xlenT    mepc,
    output exuPkg::xlenT    mtvec
);
    import exuPkg::*;

    xlenT mcause;
    xlenT newVal;

    always_comb begin
        case (addr)
            csrMepc:   rData = mepc;
            csrMcause: rData = mcause;
            csrMtvec:  rData = mtvec;
            default:   rData = '0;
        endcase
    end

    // read-modify-write value
    always_comb begin
        case (op)
            csrRw:   newVal = wData;
            csrRs:   newVal = rData | wData;
            csrRc:   newVal = rData & ~wData;
            default: newVal = rData;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mepc   <= '0;
            mcause <= '0;
            mtvec  <= '0;
        end else if (commit && ecall) begin
            mepc   <= pc;
            mcause <= causeEcallM;
        end else if (commit && (op != csrNone)) begin
            case (addr)
                csrMepc:   mepc   <= newVal;
                csrMcause: mcause <= newVal;
                csrMtvec:  mtvec  <= newVal;
                default:   mepc   <= mepc;
            endcase
        end
    end

endmodule

//--- source/exuTop.sv
/*
  Execute unit top. Payload is sampled every idle cycle and frozen at acceptance;
  register reads use the live indices while idle so a multiply loads its operands then.
*/
`timescale 1ns/1ps

module exuTop #(
    parameter int mulSteps = 64
) (
    input  logic           clk,
    input  logic           arstN,
    input  logic           inValid,
    output logic           inReady,
    input  exuPkg::regIdxT rd,
    input  exuPkg::regIdxT rs1,
    input  exuPkg::regIdxT rs2,
    input  logic           regWen,
    input  logic           srcASel,
    input  exuPkg::srcBT   srcBSel,
    input  exuPkg::aluOpT  aluOp,
    input  exuPkg::mulOpT  mulOp,
    input  exuPkg::branchT branch,
    input  exuPkg::csrOpT  csrOp,
    input  logic           ecall,
    input  logic           mret,
    input  exuPkg::xlenT   pc,
    input  exuPkg::xlenT   imm,
    output logic           resValid,
    input  logic           resReady,
    output exuPkg::xlenT   dnpc,
    output logic           wbEn,
    output exuPkg::regIdxT wbRd,
    output exuPkg::xlenT   wbData
);
    import exuPkg::*;

    logic latch, mulStart, mulStep, mulDone, commit, aluZero, aluLess;
    regIdxT rdQ, rs1Q, rs2Q, raAddr, rbAddr;
    logic regWenQ, srcASelQ, ecallQ, mretQ;
    srcBT srcBSelQ;
    aluOpT aluOpQ;
    mulOpT mulOpQ;
    branchT branchQ;
    csrOpT csrOpQ;
    xlenT pcQ, immQ, rs1Val, rs2Val, srcA, srcB, aluResult, product;
    xlenT csrRData, mepc, mtvec, dnpcNext, wbDataNext;

    // captured payload
    always_ff @(posedge clk) begin
        if (inReady) begin
            {rdQ, rs1Q, rs2Q, regWenQ, srcASelQ} <= {rd, rs1, rs2, regWen, srcASel};
            {srcBSelQ, aluOpQ, mulOpQ, branchQ} <= {srcBSel, aluOp, mulOp, branch};
            {csrOpQ, ecallQ, mretQ, pcQ, immQ} <= {csrOp, ecall, mret, pc, imm};
        end
    end

    // result register, held through back-pressure
    always_ff @(posedge clk) begin
        if (latch) begin
            {wbEn, wbRd, wbData, dnpc} <= {regWenQ, rdQ, wbDataNext, dnpcNext};
        end
    end

    assign raAddr = inReady ? rs1 : rs1Q;
    assign rbAddr = inReady ? rs2 : rs2Q;
    assign srcA   = srcASelQ ? rs1Val : pcQ;
    assign srcB   = (srcBSelQ == srcBImm) ? immQ : (srcBSelQ == srcBReg) ? rs2Val : xlenT'(4);
    assign wbDataNext = (mulOpQ != mulNone) ? product :
                        (csrOpQ != csrNone) ? csrRData : aluResult;

    exuCtrl uCtrl (.clk, .arstN, .inValid, .resReady, .mulOp, .mulDone, .inReady, .resValid,
        .latch, .mulStart, .mulStep, .commit);

    mulCounter #(.mulSteps(mulSteps)) uMulCnt (.clk, .arstN, .start(mulStart), .step(mulStep),
        .done(mulDone));

    shiftMul #(.mulSteps(mulSteps)) uMul (.clk, .arstN, .start(mulStart), .step(mulStep),
        .a(rs1Val), .b(rs2Val), .word(mulOpQ == mulMulw), .product);

    alu uAlu (.a(srcA), .b(srcB), .op(aluOpQ), .result(aluResult), .zero(aluZero),
        .less(aluLess));

    nextAddr uNext (.branch(branchQ), .zero(aluZero), .less(aluLess), .pc(pcQ), .imm(immQ),
        .rs1Val, .mepc, .mtvec, .ecall(ecallQ), .mret(mretQ), .dnpc(dnpcNext));

    regFile uRegs (.clk, .arstN, .raAddr, .rbAddr, .wAddr(wbRd), .wData(wbData),
        .wEn(commit && wbEn), .raData(rs1Val), .rbData(rs2Val));

    csrFile uCsr (.clk, .arstN, .addr(immQ[11:0]), .op(csrOpQ), .wData(rs1Val), .commit,
        .ecall(ecallQ), .pc(pcQ), .rData(csrRData), .mepc, .mtvec);

endmodule

//--- testbench/exuTop_chk.sv
/*
  Handshake and reset assertions, bound into every exuTop instance.
*/
`timescale 1ns/1ps

module exuTopChk (
    input logic           clk,
    input logic           arstN,
    input logic           inValid,
    input logic           inReady,
    input logic           resValid,
    input logic           resReady,
    input exuPkg::xlenT   dnpc,
    input logic           wbEn,
    input exuPkg::regIdxT wbRd,
    input exuPkg::xlenT   wbData
);

    // one instruction in flight, so no second acceptance and no result yet
    oneInFlight: assert property (@(posedge clk) disable iff (!arstN)
        (inValid && inReady) |=> (!inReady && !resValid))
        else $error("inReady or resValid high in the cycle after an acceptance");

    resultHeld: assert property (@(posedge clk) disable iff (!arstN)
        (resValid && !resReady) |=> (resValid && $stable(dnpc) && $stable(wbData)
                                     && $stable(wbEn) && $stable(wbRd)))
        else $error("result changed or dropped while stalled by resReady");

    resetIdle: assert property (@(posedge clk) $rose(arstN) |-> !resValid)
        else $error("resValid high in the first cycle after reset");

endmodule

bind exuTop exuTopChk uChk (
    .clk, .arstN, .inValid, .inReady, .resValid, .resReady, .dnpc, .wbEn, .wbRd, .wbData
);

//--- testbench/exuTb.sv
/*
  Testbench for exuTop. Each line of testbench/exuStim.txt is one instruction
  with its expected result; runs from the project root. Stops at the first error.
*/
`timescale 1ns/1ps

module exuTb;
    import exuPkg::*;

    localparam int mulSteps   = 64;
    localparam int readyLimit = 20;
    localparam int resLimit   = mulSteps + 20;

    logic   clk = 1'b0;
    logic   arstN, inValid, inReady, resValid, resReady;
    logic   regWen, srcASel, ecall, mret, wbEn;
    regIdxT rd, rs1, rs2, wbRd;
    srcBT   srcBSel;
    aluOpT  aluOp;
    mulOpT  mulOp;
    branchT branch;
    csrOpT  csrOp;
    xlenT   pc, imm, dnpc, wbData;

    // fields of the current stimulus line
    logic [127:0]  tName;
    logic [4:0]    fRd, fRs1, fRs2, fWbRd;
    logic [3:0]    fAluOp;
    logic [2:0]    fBranch;
    logic [1:0]    fSrcB, fMul, fCsr;
    logic          fWen, fSrcA, fEcall, fMret, fWbEn;
    logic [7:0]    fHold;
    logic [63:0]   fPc, fImm, fWbData, fDnpc;
    logic [2047:0] lineBuf;
    integer        seed, fd, nFields, nTests;

    exuTop #(.mulSteps(mulSteps)) UUT (
        .clk, .arstN, .inValid, .inReady, .rd, .rs1, .rs2, .regWen, .srcASel, .srcBSel,
        .aluOp, .mulOp, .branch, .csrOp, .ecall, .mret, .pc, .imm,
        .resValid, .resReady, .dnpc, .wbEn, .wbRd, .wbData
    );

    always #50 clk = ~clk;

    task automatic stopRun();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic checkValue(input logic [127:0] testName, input string field,
                              input logic [63:0] expected, input logic [63:0] actual);
        if (expected !== actual) begin
            $display("mismatch %0s %0s: expected %h, actual %h", testName, field,
                     expected, actual);
            stopRun();
        end
    endtask

    task automatic checkResult();
        checkValue(tName, "wbEn", 64'(fWbEn), 64'(wbEn));
        checkValue(tName, "wbRd", 64'(fWbRd), 64'(wbRd));
        checkValue(tName, "wbData", fWbData, wbData);
        checkValue(tName, "dnpc", fDnpc, dnpc);
    endtask

    // one instruction: random idle gap, input handshake, result with back-pressure
    task automatic runOne();
        int waitCnt;
        int gap;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(negedge clk);
        rd      = fRd;
        rs1     = fRs1;
        rs2     = fRs2;
        regWen  = fWen;
        srcASel = fSrcA;
        srcBSel = srcBT'(fSrcB);
        aluOp   = aluOpT'(fAluOp);
        mulOp   = mulOpT'(fMul);
        branch  = branchT'(fBranch);
        csrOp   = csrOpT'(fCsr);
        ecall   = fEcall;
        mret    = fMret;
        pc      = fPc;
        imm     = fImm;
        inValid = 1'b1;
        waitCnt = 0;
        while (!inReady) begin
            if (waitCnt == readyLimit) begin
                $display("timeout: inReady never rose for test %0s", tName);
                stopRun();
            end
            @(negedge clk);
            waitCnt++;
        end
        // accepted on the rising edge in between
        @(negedge clk);
        inValid = 1'b0;
        waitCnt = 0;
        while (!resValid) begin
            if (waitCnt == resLimit) begin
                $display("timeout: resValid never rose for test %0s", tName);
                stopRun();
            end
            @(negedge clk);
            waitCnt++;
        end
        checkResult();
        repeat (fHold) begin
            @(negedge clk);
            checkValue(tName, "resValid under back-pressure", 64'd1, 64'(resValid));
            checkValue(tName, "inReady under back-pressure", 64'd0, 64'(inReady));
            checkResult();
        end
        resReady = 1'b1;
        @(negedge clk);
        resReady = 1'b0;
        checkValue(tName, "resValid after transfer", 64'd0, 64'(resValid));
    endtask

    initial begin
        arstN    = 1'b0;
        inValid  = 1'b0;
        resReady = 1'b0;
        rd       = '0;
        rs1      = '0;
        rs2      = '0;
        regWen   = 1'b0;
        srcASel  = 1'b0;
        srcBSel  = srcBReg;
        aluOp    = aluAdd;
        mulOp    = mulNone;
        branch   = brNone;
        csrOp    = csrNone;
        ecall    = 1'b0;
        mret     = 1'b0;
        pc       = '0;
        imm      = '0;
        seed     = 32'hfd3a_0c44;
        nTests   = 0;
        repeat (10) @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);
        checkValue("reset", "inReady", 64'd1, 64'(inReady));
        checkValue("reset", "resValid", 64'd0, 64'(resValid));
        fd = $fopen("testbench/exuStim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file testbench/exuStim.txt");
            stopRun();
        end
        while (!$feof(fd)) begin
            if ($fgets(lineBuf, fd) != 0) begin
                nFields = $sscanf(lineBuf,
                    "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    tName, fRd, fRs1, fRs2, fWen, fSrcA, fSrcB, fAluOp, fMul, fBranch,
                    fCsr, fEcall, fMret, fPc, fImm, fHold, fWbEn, fWbRd, fWbData, fDnpc);
                // comment lines stop after the leading #
                if (nFields == 20) begin
                    runOne();
                    nTests++;
                end else if (nFields > 1) begin
                    $display("stimulus line has %0d fields instead of 20", nFields);
                    stopRun();
                end
            end
        end
        $fclose(fd);
        if (nTests == 0) begin
            $display("no instruction was read from the stimulus file");
            stopRun();
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

//--- testbench/exuStim.txt
# name rd rs1 rs2 regWen srcASel srcBSel aluOp mulOp branch csrOp ecall mret pc imm hold
# then wbEn wbRd wbData dnpc; fields in hex, hold is resReady low cycles
lui1 1 0 0 1 1 1 f 0 0 0 0 0 1000 123456789abcdef0 0 1 1 123456789abcdef0 1004
lui2 2 0 0 1 1 1 f 0 0 0 0 0 1004 fffffffffffffff3 2 1 2 fffffffffffffff3 1008
add 3 1 2 1 1 0 0 0 0 0 0 0 1008 0 0 1 3 123456789abcdee3 100c
sub 4 2 1 1 1 0 1 0 0 0 0 0 100c 0 1 1 4 edcba98765432103 1010
slt 5 2 1 1 1 0 3 0 0 0 0 0 1010 0 0 1 5 1 1014
sltu 6 2 1 1 1 0 4 0 0 0 0 0 1014 0 0 1 6 0 1018
sra 7 2 0 1 1 1 7 0 0 0 0 0 1018 4 0 1 7 ffffffffffffffff 101c
srl 8 1 0 1 1 1 6 0 0 0 0 0 101c 3c 0 1 8 1 1020
sllw 9 1 0 1 1 1 c 0 0 0 0 0 1020 4 0 1 9 ffffffffabcdef00 1024
addw a 1 1 1 1 0 a 0 0 0 0 0 1024 0 0 1 a 3579bde0 1028
sraw b 1 0 1 1 1 e 0 0 0 0 0 1028 8 0 1 b ffffffffff9abcde 102c
xorX0 0 1 2 1 1 0 5 0 0 0 0 0 102c 0 1 1 0 edcba98765432103 1030
readX0 d 0 5 1 1 0 0 0 0 0 0 0 1030 0 0 1 d 1 1034
or c 1 4 1 1 0 8 0 0 0 0 0 1034 0 0 1 c fffffffffffffff3 1038
sll 19 8 0 1 1 1 2 0 0 0 0 0 1038 3f 0 1 19 8000000000000000 103c
subw 1a 5 1 1 1 0 b 0 0 0 0 0 103c 0 0 1 1a 65432111 1040
beq 0 5 8 0 1 0 1 0 4 0 0 0 1100 40 0 0 0 0 1140
bne 0 5 8 0 1 0 1 0 5 0 0 0 1140 40 0 0 0 0 1144
blt 0 2 1 0 1 0 3 0 6 0 0 0 1200 fffffffffffffff0 1 0 0 1 11f0
bgeN 0 2 1 0 1 0 3 0 7 0 0 0 11f0 40 0 0 0 1 11f4
bgeT 0 1 2 0 1 0 3 0 7 0 0 0 1300 20 0 0 0 0 1320
jal e 0 0 1 0 2 0 0 1 0 0 0 2000 800 0 1 e 2004 2800
jalr f d 0 1 0 2 0 0 2 0 0 0 2800 3000 1 1 f 2804 3000
mul 10 1 2 1 1 0 0 1 0 0 0 0 3000 0 3 1 10 13579be02468add0 3004
depAdd 18 10 5 1 1 0 0 0 0 0 0 0 3004 0 0 1 18 13579be02468add1 3008
mulwNeg 11 1 5 1 1 0 0 2 0 0 0 0 3008 0 0 1 11 ffffffff9abcdef0 300c
mulwPos 1b 1 2 1 1 0 0 2 0 0 0 0 300c 0 2 1 1b 2468add0 3010
csrrw1 12 1 0 1 1 0 0 0 0 1 0 0 4000 305 0 1 12 0 4004
csrrw2 13 e 0 1 1 0 0 0 0 1 0 0 4004 305 1 1 13 123456789abcdef0 4008
csrrs 14 8 0 1 1 0 0 0 0 2 0 0 4008 305 0 1 14 2004 400c
csrrc 15 5 0 1 1 0 0 0 0 3 0 0 400c 305 0 1 15 2005 4010
ecall 0 0 0 0 1 0 0 0 0 0 1 0 5000 0 2 0 0 0 2004
mepcRd 16 0 0 1 1 0 0 0 0 2 0 0 2004 341 0 1 16 5000 2008
mcauseRd 17 0 0 1 1 0 0 0 0 2 0 0 2008 342 0 1 17 b 200c
mret 0 0 0 0 1 0 0 0 0 0 0 1 200c 0 0 0 0 0 5000

//--- list.f
source/exuPkg.sv
source/exuCtrl.sv
source/mulCounter.sv
source/shiftMul.sv
source/alu.sv
source/nextAddr.sv
source/regFile.sv
source/csrFile.sv
source/exuTop.sv
testbench/exuTop_chk.sv
testbench/exuTb.sv

//--- Bender.yml
package:
  name: exu

sources:
  - source/exuPkg.sv
  - source/exuCtrl.sv
  - source/mulCounter.sv
  - source/shiftMul.sv
  - source/alu.sv
  - source/nextAddr.sv
  - source/regFile.sv
  - source/csrFile.sv
  - source/exuTop.sv
  - target: test
    files:
      - testbench/exuTop_chk.sv
      - testbench/exuTb.sv
